//--- test/rob_stimulus.txt
# cmd, fields in hex: T name | I rvc br rd ldst pdst | W n | P n m | B n mispred taken npc
# E n cause | R ldst pdst pc | S reason redirect epc cause | Q can_enq | D drain | X reset
T fill_out_of_order
Q 3
R 01 10 80000000
R 02 11 80000004
R 03 12 80000008
R 04 13 8000000a
R 05 14 8000000e
R 06 15 80000012
R 07 16 80000014
R 08 17 80000018
R 09 18 8000001c
R 0a 19 80000020
R 0b 1a 80000022
R 0c 1b 80000026
R 0d 1c 8000002a
R 0e 1d 8000002c
R 0f 1e 80000030
R 10 1f 80000034
I 0 0 1 01 10
I 0 0 1 02 11
I 1 0 1 03 12
I 0 0 1 04 13
I 0 0 1 05 14
I 1 0 1 06 15
I 0 0 1 07 16
I 0 0 1 08 17
I 0 0 1 09 18
I 1 0 1 0a 19
I 0 0 1 0b 1a
I 0 0 1 0c 1b
I 1 0 1 0d 1c
I 0 0 1 0e 1d
I 0 0 1 0f 1e
I 0 0 1 10 1f
Q 0
W 3
W 0
W 1
W 7
W 2
W 4
W 5
W 6
W f
W 8
W 9
W a
W b
W c
W d
W e
D
T pair_retire
R 11 20 80000038
R 12 21 8000003c
I 0 0 1 11 20
I 0 0 1 12 21
P 10 11
D
T two_mispredicts
R 13 22 80000040
R 00 00 80000044
S 0 80000300 0 0
I 0 0 1 13 22
I 0 1 0 00 00
I 0 0 1 14 23
I 0 1 0 00 00
I 0 0 1 15 24
W 16
B 15 1 1 80000200
W 14
B 13 1 1 80000300
W 12
D
T exception
R 16 25 80000300
R 17 26 80000304
S 1 80000100 80000306 2
I 0 0 1 16 25
I 1 0 1 17 26
I 0 0 1 18 27
I 0 0 1 19 28
W 17
W 18
E 19 2
D
R 1a 29 80000100
R 1b 2a 80000104
I 0 0 1 1a 29
I 0 0 1 1b 2a
W 1b
W 1c
D
T except_beats_mispred
R 1c 2b 80000108
S 1 80000100 8000010c 3
I 0 0 1 1c 2b
I 0 0 1 1d 2c
I 0 1 0 00 00
E 1e 3
B 1f 1 1 80000400
W 1d
D
T after_reset
X
Q 3
R 1e 2d 80000000
R 1f 2e 80000004
I 0 0 1 1e 2d
I 1 0 1 1f 2e
W 20
W 21
D

//--- sources.f
hdl/rob_pkg.sv
hdl/rob_queue.sv
hdl/rob_event_track.sv
hdl/rob_commit.sv
hdl/rob_top.sv
test/rob_props.sv
test/rob_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SOURCES   := $(shell cat sources.f)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): sources.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f sources.f --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    localparam int ENQ_W    = 2;
    localparam int COMMIT_W = 2;
    localparam int WB_W     = 2;

    // one expected retire or squash
    typedef struct packed {
        logic            is_squash;
        logic [4:0]      ldst;
        logic [5:0]      pdst;
        logic [XLEN-1:0] pc;
        logic            reason;
        logic [XLEN-1:0] redirect;
        logic [XLEN-1:0] epc;
        logic [3:0]      cause;
    } expect_t;

    logic                clk;
    logic                rst;
    logic [ENQ_W-1:0]    can_enq;
    logic [ENQ_W-1:0]    insert;
    rob_entry_t          new_entry [ENQ_W];
    rob_idx_t            alloc_idx [ENQ_W];
    logic [WB_W-1:0]     wb_vld;
    wb_info_t            wb_info [WB_W];
    logic                branchwb_vld;
    branch_wb_t          branchwb_info;
    logic                exceptwb_vld;
    except_wb_t          exceptwb_info;
    logic [COMMIT_W-1:0] rename_commit;
    commit_info_t        rename_commit_info [COMMIT_W];
    logic                branch_commit;
    branch_commit_t      branch_commit_info;
    logic                squash_vld;
    squash_info_t        squash_info;

    expect_t    exp_q [$];
    rob_entry_t pending [$];
    rob_idx_t   idx_map [256];
    int         ins_cnt;
    int         err_cnt;
    int         check_cnt;
    int         rec_total;
    string      test_name;
    // oldest mispredict written back so far, by insert number
    int         mp_n;
    logic       mp_taken;

    rob_top #(
        .ENQ_WIDTH    (ENQ_W),
        .COMMIT_WIDTH (COMMIT_W),
        .WB_PORTS     (WB_W),
        .INIT_PC      (32'h8000_0000),
        .TRAP_VEC     (32'h8000_0100)
    ) u_rob_top (
        .clk                  (clk),
        .rst                  (rst),
        .o_can_enq            (can_enq),
        .i_insert             (insert),
        .i_new_entry          (new_entry),
        .o_alloc_idx          (alloc_idx),
        .i_wb_vld             (wb_vld),
        .i_wb_info            (wb_info),
        .i_branchwb_vld       (branchwb_vld),
        .i_branchwb_info      (branchwb_info),
        .i_exceptwb_vld       (exceptwb_vld),
        .i_exceptwb_info      (exceptwb_info),
        .o_rename_commit      (rename_commit),
        .o_rename_commit_info (rename_commit_info),
        .o_branch_commit      (branch_commit),
        .o_branch_commit_info (branch_commit_info),
        .o_squash_vld         (squash_vld),
        .o_squash_info        (squash_info)
    );

    initial begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    // advance to just after the next rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(string what, logic [31:0] exp_val, logic [31:0] act_val);
        check_cnt++;
        if (exp_val !== act_val) begin
            err_cnt++;
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp_val, act_val);
        end
    endtask

    task automatic random_delay();
        int unsigned cycles;
        cycles = $urandom % 3;
        repeat (cycles) tick();
    endtask

    // push pending entries through, two per cycle where the ROB has room
    task automatic send_inserts();
        int cnt;
        while (pending.size() > 0) begin
            cnt = 0;
            for (int k = 0; k < ENQ_W; k++) begin
                if (k < pending.size() && can_enq[k] && cnt == k) begin
                    insert[k]          = 1'b1;
                    new_entry[k]       = pending[k];
                    idx_map[ins_cnt+k] = alloc_idx[k];
                    cnt++;
                end
            end
            tick();
            insert = '0;
            repeat (cnt) void'(pending.pop_front());
            ins_cnt += cnt;
        end
    endtask

    task automatic write_common(int n, int m, logic pair);
        random_delay();
        wb_vld[0]          = 1'b1;
        wb_info[0].rob_idx = idx_map[n];
        if (pair) begin
            wb_vld[1]          = 1'b1;
            wb_info[1].rob_idx = idx_map[m];
        end
        tick();
        wb_vld = '0;
        // a pair that holds the two oldest entries leaves in one cycle
        if (pair) begin
            check_value("pair retire", 32'(2'b11), 32'(rename_commit));
        end
    endtask

    task automatic write_branch(int n, logic mispred, logic taken, logic [31:0] npc);
        random_delay();
        branchwb_vld          = 1'b1;
        branchwb_info.rob_idx = idx_map[n];
        branchwb_info.mispred = mispred;
        branchwb_info.taken   = taken;
        branchwb_info.npc     = npc;
        // earlier in program order wins
        if (mispred && (mp_n < 0 || n < mp_n)) begin
            mp_n     = n;
            mp_taken = taken;
        end
        tick();
        branchwb_vld = 1'b0;
    endtask

    task automatic write_except(int n, logic [3:0] cause);
        random_delay();
        exceptwb_vld          = 1'b1;
        exceptwb_info.rob_idx = idx_map[n];
        exceptwb_info.cause   = exc_cause_e'(cause);
        tick();
        exceptwb_vld = 1'b0;
    endtask

    task automatic wait_drained();
        int left;
        for (int i = 0; i < 200 && exp_q.size() > 0; i++) begin
            tick();
        end
        left = exp_q.size();
        if (left > 0) begin
            err_cnt++;
            $display("%s: %0d expected retire or squash records never happened",
                     test_name, left);
            exp_q.delete();
        end
        tick();
    endtask

    task automatic apply_reset();
        rst  = 1'b1;
        mp_n = -1;
        repeat (16) tick();
        rst = 1'b0;
    endtask

    // sampled mid-cycle where the registered outputs have settled
    always @(negedge clk) begin
        expect_t         e;
        logic [XLEN-1:0] last_pc;
        if (!rst) begin
            if (branch_commit && !squash_vld) begin
                err_cnt++;
                $display("%s: branch commit without a squash", test_name);
            end
            for (int c = 0; c < COMMIT_W; c++) begin
                if (rename_commit[c]) begin
                    if (exp_q.size() == 0 || exp_q[0].is_squash) begin
                        err_cnt++;
                        $display("%s: unexpected retire of pc %h in slot %0d",
                                 test_name, rename_commit_info[c].pc, c);
                    end else begin
                        e       = exp_q.pop_front();
                        last_pc = e.pc;
                        check_value("retire ldst", 32'(e.ldst), 32'(rename_commit_info[c].ldst));
                        check_value("retire pdst", 32'(e.pdst), 32'(rename_commit_info[c].pdst));
                        check_value("retire pc", e.pc, rename_commit_info[c].pc);
                    end
                end
            end
            if (squash_vld) begin
                if (exp_q.size() == 0 || !exp_q[0].is_squash) begin
                    err_cnt++;
                    $display("%s: unexpected squash to %h", test_name, squash_info.redirect_pc);
                end else begin
                    e = exp_q.pop_front();
                    check_value("squash reason", 32'(e.reason), 32'(squash_info.reason));
                    check_value("squash redirect", e.redirect, squash_info.redirect_pc);
                    if (e.reason) begin
                        check_value("squash epc", e.epc, squash_info.epc);
                        check_value("squash cause", 32'(e.cause), 32'(squash_info.cause));
                    end else if (!branch_commit) begin
                        err_cnt++;
                        $display("%s: mispredict squash without a branch commit", test_name);
                    end else begin
                        // the branch is the last slot retired in this cycle
                        check_value("branch pc", last_pc, branch_commit_info.pc);
                        check_value("branch npc", e.redirect, branch_commit_info.npc);
                        check_value("branch taken", 32'(mp_taken),
                                    32'(branch_commit_info.taken));
                    end
                end
                mp_n = -1;
            end
        end
    end

    // limit scales with the number of stimulus records
    initial begin
        wait (rec_total > 0);
        repeat (200 * rec_total) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", 200 * rec_total);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int          fd;
        int          unused;
        string       line;
        string       rest;
        byte         cmd;
        expect_t     e;
        rob_entry_t  ent;
        logic [31:0] a [5];
        rst           = 1'b1;
        insert        = '0;
        wb_vld        = '0;
        branchwb_vld  = 1'b0;
        branchwb_info = '0;
        exceptwb_vld  = 1'b0;
        exceptwb_info = '0;
        for (int k = 0; k < ENQ_W; k++) begin
            new_entry[k] = '0;
        end
        for (int p = 0; p < WB_W; p++) begin
            wb_info[p] = '0;
        end
        ins_cnt   = 0;
        err_cnt   = 0;
        check_cnt = 0;
        rec_total = 0;
        mp_n      = -1;
        mp_taken  = 1'b0;
        test_name = "reset";
        unused    = $urandom(32'h1aed);

        fd = $fopen("test/rob_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/rob_stimulus.txt");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    rec_total++;
                end
            end
            $fclose(fd);
            fd = $fopen("test/rob_stimulus.txt", "r");

            repeat (16) @(posedge clk);
            #2;
            rst = 1'b0;

            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cmd  = line.getc(0);
                    rest = line.substr(1, line.len() - 1);
                    a    = '{default: '0};
                    if (cmd != "I" && cmd != "T") begin
                        send_inserts();
                    end
                    if (cmd == "T") begin
                        unused = $sscanf(rest, "%s", test_name);
                    end else begin
                        unused = $sscanf(rest, "%h %h %h %h %h", a[0], a[1], a[2], a[3], a[4]);
                    end
                    e = '0;
                    case (cmd)
                        "I": begin
                            ent.is_rvc    = a[0][0];
                            ent.is_branch = a[1][0];
                            ent.rd_valid  = a[2][0];
                            ent.ldst      = a[3][4:0];
                            ent.pdst      = a[4][5:0];
                            pending.push_back(ent);
                        end
                        "W": write_common(int'(a[0]), 0, 1'b0);
                        "P": write_common(int'(a[0]), int'(a[1]), 1'b1);
                        "B": write_branch(int'(a[0]), a[1][0], a[2][0], a[3]);
                        "E": write_except(int'(a[0]), a[1][3:0]);
                        "R": begin
                            e.ldst = a[0][4:0];
                            e.pdst = a[1][5:0];
                            e.pc   = a[2];
                            exp_q.push_back(e);
                        end
                        "S": begin
                            e.is_squash = 1'b1;
                            e.reason    = a[0][0];
                            e.redirect  = a[1];
                            e.epc       = a[2];
                            e.cause     = a[3][3:0];
                            exp_q.push_back(e);
                        end
                        "Q": check_value("can_enq", a[0], 32'(can_enq));
                        "D": wait_drained();
                        "X": apply_reset();
                        default: ;
                    endcase
                end
            end
            $fclose(fd);
            send_inserts();
            wait_drained();

            $display("checks %0d, errors %0d", check_cnt, err_cnt);
            if (err_cnt == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

//--- test/rob_props.sv
`timescale 1ns/1ps

module rob_props #(
    parameter int ENQ_WIDTH = 2
) (
    input logic                 clk,
    input logic                 rst,
    input logic [ENQ_WIDTH-1:0] o_can_enq,
    input logic [ENQ_WIDTH-1:0] i_insert,
    input logic                 o_squash_vld
);

    a_insert_allowed: assert property (@(posedge clk) disable iff (rst)
        (i_insert & ~o_can_enq) == '0)
        else $error("insert into a slot that cannot enqueue");

    a_squash_pulse: assert property (@(posedge clk) disable iff (rst)
        o_squash_vld |=> !o_squash_vld)
        else $error("squash held for more than one cycle");

    // queue empty after the flush edge
    a_empty_after_squash: assert property (@(posedge clk) disable iff (rst)
        o_squash_vld |=> (&o_can_enq))
        else $error("enqueue not fully open after a squash");

endmodule

bind rob_top rob_props #(.ENQ_WIDTH(ENQ_WIDTH)) u_rob_props (
    .clk          (clk),
    .rst          (rst),
    .o_can_enq    (o_can_enq),
    .i_insert     (i_insert),
    .o_squash_vld (o_squash_vld)
);

//--- hdl/rob_top.sv
`timescale 1ns/1ps

module rob_top #(
    parameter int                        ENQ_WIDTH    = 2,
    parameter int                        COMMIT_WIDTH = 2,
    parameter int                        WB_PORTS     = 2,
    parameter logic [rob_pkg::XLEN-1:0] INIT_PC      = 32'h8000_0000,
    parameter logic [rob_pkg::XLEN-1:0] TRAP_VEC     = 32'h8000_0100
) (
    input  logic                    clk,
    input  logic                    rst,
    // dispatch
    output logic [ENQ_WIDTH-1:0]    o_can_enq,
    input  logic [ENQ_WIDTH-1:0]    i_insert,
    input  rob_pkg::rob_entry_t     i_new_entry [ENQ_WIDTH],
    output rob_pkg::rob_idx_t       o_alloc_idx [ENQ_WIDTH],
    // writeback
    input  logic [WB_PORTS-1:0]     i_wb_vld,
    input  rob_pkg::wb_info_t       i_wb_info [WB_PORTS],
    input  logic                    i_branchwb_vld,
    input  rob_pkg::branch_wb_t     i_branchwb_info,
    input  logic                    i_exceptwb_vld,
    input  rob_pkg::except_wb_t     i_exceptwb_info,
    // retirement
    output logic [COMMIT_WIDTH-1:0] o_rename_commit,
    output rob_pkg::commit_info_t   o_rename_commit_info [COMMIT_WIDTH],
    output logic                    o_branch_commit,
    output rob_pkg::branch_commit_t o_branch_commit_info,
    output logic                    o_squash_vld,
    output rob_pkg::squash_info_t   o_squash_info
);
    import rob_pkg::*;

    logic [COMMIT_WIDTH-1:0]           window_vld;
    rob_idx_t                          window_idx [COMMIT_WIDTH];
    rob_entry_t                        window_entry [COMMIT_WIDTH];
    logic [$clog2(COMMIT_WIDTH+1)-1:0] retire_cnt;
    logic                              flush;
    logic                              mispred_vld;
    branch_wb_t                        mispred_info;
    logic                              except_vld;
    except_wb_t                        except_info;

    rob_queue #(
        .ENQ_WIDTH    (ENQ_WIDTH),
        .COMMIT_WIDTH (COMMIT_WIDTH),
        .WB_PORTS     (WB_PORTS)
    ) u_rob_queue (
        .clk             (clk),
        .rst             (rst),
        .o_can_enq       (o_can_enq),
        .i_insert        (i_insert),
        .i_new_entry     (i_new_entry),
        .o_alloc_idx     (o_alloc_idx),
        .i_wb_vld        (i_wb_vld),
        .i_wb_info       (i_wb_info),
        .i_branchwb_vld  (i_branchwb_vld),
        .i_branchwb_info (i_branchwb_info),
        .i_exceptwb_vld  (i_exceptwb_vld),
        .i_exceptwb_info (i_exceptwb_info),
        .o_window_vld    (window_vld),
        .o_window_idx    (window_idx),
        .o_window_entry  (window_entry),
        .i_retire_cnt    (retire_cnt),
        .i_flush         (flush)
    );

    rob_event_track u_rob_event_track (
        .clk             (clk),
        .rst             (rst),
        .i_branchwb_vld  (i_branchwb_vld),
        .i_branchwb_info (i_branchwb_info),
        .i_exceptwb_vld  (i_exceptwb_vld),
        .i_exceptwb_info (i_exceptwb_info),
        .i_flush         (flush),
        .o_mispred_vld   (mispred_vld),
        .o_mispred_info  (mispred_info),
        .o_except_vld    (except_vld),
        .o_except_info   (except_info)
    );

    rob_commit #(
        .COMMIT_WIDTH (COMMIT_WIDTH),
        .INIT_PC      (INIT_PC),
        .TRAP_VEC     (TRAP_VEC)
    ) u_rob_commit (
        .clk                  (clk),
        .rst                  (rst),
        .i_window_vld         (window_vld),
        .i_window_idx         (window_idx),
        .i_window_entry       (window_entry),
        .i_mispred_vld        (mispred_vld),
        .i_mispred_info       (mispred_info),
        .i_except_vld         (except_vld),
        .i_except_info        (except_info),
        .o_retire_cnt         (retire_cnt),
        .o_flush              (flush),
        .o_rename_commit      (o_rename_commit),
        .o_rename_commit_info (o_rename_commit_info),
        .o_branch_commit      (o_branch_commit),
        .o_branch_commit_info (o_branch_commit_info),
        .o_squash_vld         (o_squash_vld),
        .o_squash_info        (o_squash_info)
    );

endmodule

//--- hdl/rob_commit.sv
`timescale 1ns/1ps

module rob_commit #(
    parameter int                        COMMIT_WIDTH = 2,
    parameter logic [rob_pkg::XLEN-1:0] INIT_PC      = 32'h8000_0000,
    parameter logic [rob_pkg::XLEN-1:0] TRAP_VEC     = 32'h8000_0100
) (
    input  logic                              clk,
    input  logic                              rst,
    // commit window from the queue
    input  logic [COMMIT_WIDTH-1:0]           i_window_vld,
    input  rob_pkg::rob_idx_t                 i_window_idx [COMMIT_WIDTH],
    input  rob_pkg::rob_entry_t               i_window_entry [COMMIT_WIDTH],
    // held events
    input  logic                              i_mispred_vld,
    input  rob_pkg::branch_wb_t               i_mispred_info,
    input  logic                              i_except_vld,
    input  rob_pkg::except_wb_t               i_except_info,
    // queue control
    output logic [$clog2(COMMIT_WIDTH+1)-1:0] o_retire_cnt,
    output logic                              o_flush,
    // rename, frontend and pipeline
    output logic [COMMIT_WIDTH-1:0]           o_rename_commit,
    output rob_pkg::commit_info_t             o_rename_commit_info [COMMIT_WIDTH],
    output logic                              o_branch_commit,
    output rob_pkg::branch_commit_t           o_branch_commit_info,
    output logic                              o_squash_vld,
    output rob_pkg::squash_info_t             o_squash_info
);
    import rob_pkg::*;

    logic [XLEN-1:0] arch_pc_q;
    logic [XLEN-1:0] arch_pc_nxt;
    logic [XLEN-1:0] slot_pc [COMMIT_WIDTH+1];

    // pc of each window slot, chained from the architectural pc
    always_comb begin
        slot_pc[0] = arch_pc_q;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            slot_pc[c+1] = slot_pc[c] + (i_window_entry[c].is_rvc ? XLEN'(2) : XLEN'(4));
        end
    end

    always_comb begin
        logic stop;
        stop                 = 1'b0;
        o_rename_commit      = '0;
        o_retire_cnt         = '0;
        o_squash_vld         = 1'b0;
        o_squash_info        = '0;
        o_branch_commit      = 1'b0;
        o_branch_commit_info = '0;
        arch_pc_nxt          = arch_pc_q;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            if (i_window_vld[c] && !stop) begin
                if (i_except_vld && (i_window_idx[c] == i_except_info.rob_idx)) begin
                    // faulting slot stays behind, trap redirect
                    stop                      = 1'b1;
                    o_squash_vld              = 1'b1;
                    o_squash_info.reason      = sq_except;
                    o_squash_info.redirect_pc = TRAP_VEC;
                    o_squash_info.epc         = slot_pc[c];
                    o_squash_info.cause       = i_except_info.cause;
                    arch_pc_nxt               = TRAP_VEC;
                end else begin
                    o_rename_commit[c] = 1'b1;
                    o_retire_cnt       = o_retire_cnt + 1'b1;
                    arch_pc_nxt        = slot_pc[c+1];
                    if (i_mispred_vld && i_window_entry[c].is_branch &&
                        (i_window_idx[c] == i_mispred_info.rob_idx)) begin
                        // branch itself retires, younger slots are flushed
                        stop                      = 1'b1;
                        o_squash_vld              = 1'b1;
                        o_squash_info.reason      = sq_mispred;
                        o_squash_info.redirect_pc = i_mispred_info.npc;
                        o_branch_commit           = 1'b1;
                        o_branch_commit_info.pc   = slot_pc[c];
                        o_branch_commit_info.npc  = i_mispred_info.npc;
                        o_branch_commit_info.taken = i_mispred_info.taken;
                        arch_pc_nxt               = i_mispred_info.npc;
                    end
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            o_rename_commit_info[c].rd_valid = i_window_entry[c].rd_valid;
            o_rename_commit_info[c].ldst     = i_window_entry[c].ldst;
            o_rename_commit_info[c].pdst     = i_window_entry[c].pdst;
            o_rename_commit_info[c].pc       = slot_pc[c];
        end
    end

    assign o_flush = o_squash_vld;

    always_ff @(posedge clk) begin
        if (rst) begin
            arch_pc_q <= INIT_PC;
        end else begin
            arch_pc_q <= arch_pc_nxt;
        end
    end

endmodule

//--- hdl/rob_event_track.sv
`timescale 1ns/1ps

module rob_event_track (
    input  logic                clk,
    input  logic                rst,
    // from execution units
    input  logic                i_branchwb_vld,
    input  rob_pkg::branch_wb_t i_branchwb_info,
    input  logic                i_exceptwb_vld,
    input  rob_pkg::except_wb_t i_exceptwb_info,
    // from commit
    input  logic                i_flush,
    // held events
    output logic                o_mispred_vld,
    output rob_pkg::branch_wb_t o_mispred_info,
    output logic                o_except_vld,
    output rob_pkg::except_wb_t o_except_info
);
    import rob_pkg::*;

    logic       mispred_vld_q;
    branch_wb_t mispred_q;
    logic       except_vld_q;
    except_wb_t except_q;
    logic       take_mispred;
    logic       take_except;

    // keep only the oldest one seen so far
    assign take_mispred = i_branchwb_vld && i_branchwb_info.mispred &&
                          (!mispred_vld_q || is_older(i_branchwb_info.rob_idx, mispred_q.rob_idx));

    assign take_except = i_exceptwb_vld &&
                         (!except_vld_q || is_older(i_exceptwb_info.rob_idx, except_q.rob_idx));

    always_ff @(posedge clk) begin
        if (rst) begin
            mispred_vld_q <= 1'b0;
            except_vld_q  <= 1'b0;
        end else if (i_flush) begin
            // writebacks in the squash cycle belong to flushed entries
            mispred_vld_q <= 1'b0;
            except_vld_q  <= 1'b0;
        end else begin
            if (take_mispred) begin
                mispred_vld_q <= 1'b1;
            end
            if (take_except) begin
                except_vld_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_mispred) begin
            mispred_q <= i_branchwb_info;
        end
        if (take_except) begin
            except_q <= i_exceptwb_info;
        end
    end

    assign o_mispred_vld  = mispred_vld_q;
    assign o_mispred_info = mispred_q;
    assign o_except_vld   = except_vld_q;
    assign o_except_info  = except_q;

endmodule

//--- hdl/rob_queue.sv
`timescale 1ns/1ps

module rob_queue #(
    parameter int ENQ_WIDTH    = 2,
    parameter int COMMIT_WIDTH = 2,
    parameter int WB_PORTS     = 2
) (
    input  logic                              clk,
    input  logic                              rst,
    // dispatch
    output logic [ENQ_WIDTH-1:0]              o_can_enq,
    input  logic [ENQ_WIDTH-1:0]              i_insert,
    input  rob_pkg::rob_entry_t               i_new_entry [ENQ_WIDTH],
    output rob_pkg::rob_idx_t                 o_alloc_idx [ENQ_WIDTH],
    // writeback
    input  logic [WB_PORTS-1:0]               i_wb_vld,
    input  rob_pkg::wb_info_t                 i_wb_info [WB_PORTS],
    input  logic                              i_branchwb_vld,
    input  rob_pkg::branch_wb_t               i_branchwb_info,
    input  logic                              i_exceptwb_vld,
    input  rob_pkg::except_wb_t               i_exceptwb_info,
    // commit window
    output logic [COMMIT_WIDTH-1:0]           o_window_vld,
    output rob_pkg::rob_idx_t                 o_window_idx [COMMIT_WIDTH],
    output rob_pkg::rob_entry_t               o_window_entry [COMMIT_WIDTH],
    input  logic [$clog2(COMMIT_WIDTH+1)-1:0] i_retire_cnt,
    input  logic                              i_flush
);
    import rob_pkg::*;

    localparam int PTR_W = ROB_IDX_W + 1;

    rob_entry_t                     entries [ROB_SIZE];
    logic [ROB_SIZE-1:0]            valid_q;
    logic [ROB_SIZE-1:0]            done_q;
    rob_idx_t                       head_q;
    rob_idx_t                       tail_q;
    rob_idx_t                       head_nxt;
    logic [PTR_W-1:0]               used;
    logic [PTR_W-1:0]               free_cnt;
    logic [ENQ_WIDTH-1:0]           enq_ok;
    logic [$clog2(ENQ_WIDTH+1)-1:0] enq_cnt;

    // occupancy straight from the flipped pointers
    assign used     = PTR_W'(tail_q - head_q);
    assign free_cnt = PTR_W'(ROB_SIZE) - used;
    assign head_nxt = rob_idx_t'(head_q + PTR_W'(i_retire_cnt));

    always_comb begin
        enq_cnt = '0;
        for (int k = 0; k < ENQ_WIDTH; k++) begin
            // slot k needs k+1 free entries
            o_can_enq[k]   = (free_cnt > PTR_W'(k)) && !i_flush;
            o_alloc_idx[k] = rob_idx_t'(tail_q + PTR_W'(k));
            enq_ok[k]      = i_insert[k] && o_can_enq[k];
            if (enq_ok[k]) begin
                enq_cnt = enq_cnt + 1'b1;
            end
        end
    end

    // oldest entries, valid only up to the first incomplete one
    always_comb begin
        logic chain;
        chain = 1'b1;
        for (int c = 0; c < COMMIT_WIDTH; c++) begin
            o_window_idx[c]   = rob_idx_t'(head_q + PTR_W'(c));
            o_window_entry[c] = entries[o_window_idx[c].idx];
            chain = chain && valid_q[o_window_idx[c].idx] && done_q[o_window_idx[c].idx];
            o_window_vld[c]   = chain;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else if (i_flush) begin
            // older slots still retire this cycle, everything younger goes
            head_q  <= head_nxt;
            tail_q  <= head_nxt;
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            head_q <= head_nxt;
            tail_q <= rob_idx_t'(tail_q + PTR_W'(enq_cnt));
            for (int k = 0; k < ENQ_WIDTH; k++) begin
                if (enq_ok[k]) begin
                    valid_q[o_alloc_idx[k].idx] <= 1'b1;
                    done_q[o_alloc_idx[k].idx]  <= 1'b0;
                end
            end
            for (int p = 0; p < WB_PORTS; p++) begin
                if (i_wb_vld[p]) begin
                    done_q[i_wb_info[p].rob_idx.idx] <= 1'b1;
                end
            end
            if (i_branchwb_vld) begin
                done_q[i_branchwb_info.rob_idx.idx] <= 1'b1;
            end
            // faulting entry counts as complete, the cause lives in the event tracker
            if (i_exceptwb_vld) begin
                done_q[i_exceptwb_info.rob_idx.idx] <= 1'b1;
            end
            for (int c = 0; c < COMMIT_WIDTH; c++) begin
                if (c < int'(i_retire_cnt)) begin
                    valid_q[o_window_idx[c].idx] <= 1'b0;
                end
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        for (int k = 0; k < ENQ_WIDTH; k++) begin
            if (enq_ok[k]) begin
                entries[o_alloc_idx[k].idx] <= i_new_entry[k];
            end
        end
    end

endmodule

//--- hdl/rob_pkg.sv
package rob_pkg;

    localparam int XLEN = 32;
    localparam int ROB_IDX_W = 4;
    localparam int ROB_SIZE = 1 << ROB_IDX_W;

    // flipped toggles each time a pointer wraps
    typedef struct packed {
        logic                 flipped;
        logic [ROB_IDX_W-1:0] idx;
    } rob_idx_t;

    typedef struct packed {
        logic       is_rvc;
        logic       is_branch;
        logic       rd_valid;
        logic [4:0] ldst;
        logic [5:0] pdst;
    } rob_entry_t;

    typedef struct packed {
        rob_idx_t rob_idx;
    } wb_info_t;

    typedef struct packed {
        rob_idx_t         rob_idx;
        logic             mispred;
        logic             taken;
        logic [XLEN-1:0]  npc;
    } branch_wb_t;

    // riscv mcause codes
    typedef enum logic [3:0] {
        exc_illegal_instr    = 4'd2,
        exc_breakpoint       = 4'd3,
        exc_load_misaligned  = 4'd4,
        exc_store_misaligned = 4'd6,
        exc_ecall            = 4'd11
    } exc_cause_e;

    typedef struct packed {
        rob_idx_t   rob_idx;
        exc_cause_e cause;
    } except_wb_t;

    typedef struct packed {
        logic            rd_valid;
        logic [4:0]      ldst;
        logic [5:0]      pdst;
        logic [XLEN-1:0] pc;
    } commit_info_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] npc;
        logic            taken;
    } branch_commit_t;

    typedef enum logic {
        sq_mispred,
        sq_except
    } squash_reason_e;

    typedef struct packed {
        squash_reason_e  reason;
        logic [XLEN-1:0] redirect_pc;
        logic [XLEN-1:0] epc;
        exc_cause_e      cause;
    } squash_info_t;

    // same lap: lower idx is older; across a wrap the higher idx is older
    function automatic logic is_older(rob_idx_t a, rob_idx_t b);
        if (a.flipped == b.flipped) begin
            return a.idx < b.idx;
        end
        return a.idx > b.idx;
    endfunction

endpackage
